// ==== verilog/vrf_pkg.sv ====
// Vector register file geometry

package vrf_pkg;

  //////////////////////////////////////////////////
  // Banks and addressing
  //////////////////////////////////////////////////

  // Bank is picked by the low address bits
  localparam int unsigned NrBanks      = 4;
  localparam int unsigned BankSelWidth = 2;

  // Register vs starts at word vs * WordsPerVreg
  localparam int unsigned WordsPerVreg = 8;
  localparam int unsigned VAddrWidth   = 8;

  typedef logic [VAddrWidth-1:0] vaddr_t;

  //////////////////////////////////////////////////
  // Data words
  //////////////////////////////////////////////////

  localparam int unsigned ElenWidth = 64;
  localparam int unsigned ElenBytes = ElenWidth / 8;

  typedef logic [ElenWidth-1:0] elen_t;
  typedef logic [ElenBytes-1:0] strb_t;

  //////////////////////////////////////////////////
  // Instructions in flight
  //////////////////////////////////////////////////

  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] hazard_vec_t;

endpackage

// ==== verilog/opreq_pkg.sv ====
// Operand requester definitions

package opreq_pkg;

  //////////////////////////////////////////////////
  // Masters of the bank arbiters
  //////////////////////////////////////////////////

  localparam int unsigned NrOperandQueues = 4;

  // Queues first, then the two write ports
  localparam int unsigned NrMasters       = 6;
  localparam int unsigned AluWriteMaster  = 4;
  localparam int unsigned LoadWriteMaster = 5;

  typedef enum logic [1:0] {
    ALU_A   = 2'd0,
    ALU_B   = 2'd1,
    STORE_A = 2'd2,
    MASK_B  = 2'd3
  } opqueue_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Element count of one command
  typedef logic [6:0] vlen_t;

  //////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////

  typedef struct packed {
    vrf_pkg::vid_t        id;
    logic [4:0]           vs;
    eew_e                 eew;
    vlen_t                vl;
    vrf_pkg::hazard_vec_t hazard;
  } operand_request_t;

  typedef struct packed {
    eew_e  eew;
    vlen_t vl;
  } operand_queue_cmd_t;

endpackage

// ==== verilog/vrf_master_if.sv ====
// VRF master request bundle

`timescale 1ns/100ps

interface vrf_master_if;

  // Request side, held until granted or withdrawn
  logic                req;
  vrf_pkg::vaddr_t     addr;
  logic                wen;
  vrf_pkg::elen_t      wdata;
  vrf_pkg::strb_t      be;
  opreq_pkg::opqueue_e tgt;

  // Grant comes back in the request cycle
  logic                gnt;

  modport master (
    output req,
    output addr,
    output wen,
    output wdata,
    output be,
    output tgt,
    input  gnt
  );

  modport arbiter (
    input  req,
    input  addr,
    input  wen,
    input  wdata,
    input  be,
    input  tgt,
    output gnt
  );

endinterface

// ==== verilog/operand_fetch_unit.sv ====
// Operand fetch unit

`timescale 1ns/100ps

module operand_fetch_unit #(
  parameter opreq_pkg::opqueue_e Queue = opreq_pkg::ALU_A
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Command from the lane sequencer
  input  opreq_pkg::operand_request_t                  request_i,
  input  logic                                         request_valid_i,
  output logic                                         request_ready_o,
  // Operand queue
  output opreq_pkg::operand_queue_cmd_t                queue_cmd_o,
  output logic                                         queue_cmd_valid_o,
  input  logic                                         queue_ready_i,
  output logic                                         issued_o,
  // Hazard tracking
  input  vrf_pkg::hazard_vec_t [vrf_pkg::NrVInsn-1:0] hazard_table_i,
  input  vrf_pkg::hazard_vec_t                         written_i,
  // Read requests to the bank arbiters
  vrf_master_if.master                                 vrf_o
);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e               state_d, state_q;
  vrf_pkg::vid_t        id_d, id_q;
  vrf_pkg::vaddr_t      addr_d, addr_q;
  opreq_pkg::vlen_t     len_d, len_q;
  opreq_pkg::eew_e      eew_d, eew_q;
  vrf_pkg::hazard_vec_t hazard_d, hazard_q;

  opreq_pkg::vlen_t per_word;
  logic             stall;
  logic             last_gnt;
  logic             accept;

  // Elements packed into one 64-bit word
  assign per_word = opreq_pkg::vlen_t'(vrf_pkg::ElenBytes >> eew_q);

  // Stall on any hazard whose instruction did not write last cycle
  assign stall = |(hazard_q & ~written_i);

  //////////////////////////////////////////////////
  // Read request
  //////////////////////////////////////////////////

  assign vrf_o.req   = (state_q == REQUESTING) && queue_ready_i && !stall;
  assign vrf_o.addr  = addr_q;
  assign vrf_o.wen   = 1'b0;
  assign vrf_o.wdata = '0;
  assign vrf_o.be    = '0;
  assign vrf_o.tgt   = Queue;

  assign issued_o = vrf_o.gnt;

  //////////////////////////////////////////////////
  // Command acceptance
  //////////////////////////////////////////////////

  // Last word granted frees the unit in the same cycle
  assign last_gnt = vrf_o.gnt && (len_q <= per_word);
  assign accept   = request_valid_i && ((state_q == IDLE) || last_gnt);

  assign request_ready_o   = accept;
  assign queue_cmd_o       = '{eew: request_i.eew, vl: request_i.vl};
  assign queue_cmd_valid_o = accept && (request_i.vl != '0);

  always_comb begin : p_next
    state_d  = state_q;
    id_d     = id_q;
    addr_d   = addr_q;
    len_d    = len_q;
    eew_d    = eew_q;
    hazard_d = hazard_q;

    if (vrf_o.gnt) begin
      addr_d = addr_q + 1'b1;
      len_d  = last_gnt ? '0 : len_q - per_word;
      if (last_gnt) begin
        state_d = IDLE;
      end
    end

    // A zero-length command is only acknowledged
    if (accept) begin
      state_d  = (request_i.vl != '0) ? REQUESTING : IDLE;
      id_d     = request_i.id;
      addr_d   = vrf_pkg::vaddr_t'(request_i.vs * vrf_pkg::WordsPerVreg);
      len_d    = request_i.vl;
      eew_d    = request_i.eew;
      hazard_d = request_i.hazard;
    end

    // Follow the global table as older instructions retire
    hazard_d = hazard_d & hazard_table_i[id_d];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      id_q     <= '0;
      addr_q   <= '0;
      len_q    <= '0;
      eew_q    <= opreq_pkg::EW8;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      id_q     <= id_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      eew_q    <= eew_d;
      hazard_q <= hazard_d;
    end
  end

  // No request and no grant while idle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> !vrf_o.req && !vrf_o.gnt);

endmodule

// ==== verilog/vrf_bank_arbiter.sv ====
// VRF bank arbiter

`timescale 1ns/100ps

module vrf_bank_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  vrf_master_if.arbiter                                masters [opreq_pkg::NrMasters],
  output logic                [vrf_pkg::NrBanks-1:0] vrf_req_o,
  output vrf_pkg::vaddr_t     [vrf_pkg::NrBanks-1:0] vrf_addr_o,
  output logic                [vrf_pkg::NrBanks-1:0] vrf_wen_o,
  output vrf_pkg::elen_t      [vrf_pkg::NrBanks-1:0] vrf_wdata_o,
  output vrf_pkg::strb_t      [vrf_pkg::NrBanks-1:0] vrf_be_o,
  output opreq_pkg::opqueue_e [vrf_pkg::NrBanks-1:0] vrf_tgt_o
);

  typedef logic [$clog2(opreq_pkg::NrMasters)-1:0] midx_t;

  logic                [opreq_pkg::NrMasters-1:0] mst_req;
  vrf_pkg::vaddr_t     mst_addr  [opreq_pkg::NrMasters];
  logic                [opreq_pkg::NrMasters-1:0] mst_wen;
  vrf_pkg::elen_t      mst_wdata [opreq_pkg::NrMasters];
  vrf_pkg::strb_t      mst_be    [opreq_pkg::NrMasters];
  opreq_pkg::opqueue_e mst_tgt   [opreq_pkg::NrMasters];
  logic                [opreq_pkg::NrMasters-1:0] mst_gnt;

  logic  [vrf_pkg::NrBanks-1:0][opreq_pkg::NrMasters-1:0] bank_req;
  logic  [vrf_pkg::NrBanks-1:0][opreq_pkg::NrMasters-1:0] bank_gnt;
  logic  [vrf_pkg::NrBanks-1:0]                           hp_valid, lp_valid;
  midx_t [vrf_pkg::NrBanks-1:0]                           hp_win, lp_win, win;
  midx_t [vrf_pkg::NrBanks-1:0]                           hp_ptr_q, lp_ptr_q;

  // ALU operands and the ALU write form the high level
  function automatic logic is_high_prio(input int m);
    return (m == int'(opreq_pkg::ALU_A)) || (m == int'(opreq_pkg::ALU_B)) ||
           (m == opreq_pkg::AluWriteMaster);
  endfunction

  for (genvar m = 0; m < opreq_pkg::NrMasters; m++) begin : g_master
    assign mst_req[m]      = masters[m].req;
    assign mst_addr[m]     = masters[m].addr;
    assign mst_wen[m]      = masters[m].wen;
    assign mst_wdata[m]    = masters[m].wdata;
    assign mst_be[m]       = masters[m].be;
    assign mst_tgt[m]      = masters[m].tgt;
    assign masters[m].gnt  = mst_gnt[m];
  end

  //////////////////////////////////////////////////
  // Per-bank selection
  //////////////////////////////////////////////////

  always_comb begin : p_select
    int cand;
    hp_valid = '0;
    lp_valid = '0;
    hp_win   = '0;
    lp_win   = '0;
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      for (int m = 0; m < opreq_pkg::NrMasters; m++) begin
        bank_req[b][m] = mst_req[m] && (int'(mst_addr[m][vrf_pkg::BankSelWidth-1:0]) == b);
      end
      // Scan from the pointer so the last winner goes last
      for (int off = 0; off < opreq_pkg::NrMasters; off++) begin
        cand = (int'(hp_ptr_q[b]) + off) % opreq_pkg::NrMasters;
        if (!hp_valid[b] && bank_req[b][cand] && is_high_prio(cand)) begin
          hp_valid[b] = 1'b1;
          hp_win[b]   = midx_t'(cand);
        end
        cand = (int'(lp_ptr_q[b]) + off) % opreq_pkg::NrMasters;
        if (!lp_valid[b] && bank_req[b][cand] && !is_high_prio(cand)) begin
          lp_valid[b] = 1'b1;
          lp_win[b]   = midx_t'(cand);
        end
      end
    end
  end

  always_comb begin : p_grant
    mst_gnt = '0;
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      win[b] = hp_valid[b] ? hp_win[b] : lp_win[b];
      for (int m = 0; m < opreq_pkg::NrMasters; m++) begin
        bank_gnt[b][m] = (hp_valid[b] || lp_valid[b]) && (int'(win[b]) == m);
      end
      mst_gnt = mst_gnt | bank_gnt[b];

      // Bank takes the winner directly without back-pressure
      vrf_req_o[b]   = hp_valid[b] || lp_valid[b];
      vrf_addr_o[b]  = mst_addr[win[b]] >> vrf_pkg::BankSelWidth;
      vrf_wen_o[b]   = mst_wen[win[b]];
      vrf_wdata_o[b] = mst_wdata[win[b]];
      vrf_be_o[b]    = mst_be[win[b]];
      vrf_tgt_o[b]   = mst_tgt[win[b]];
    end
  end

  //////////////////////////////////////////////////
  // Round-robin pointers
  //////////////////////////////////////////////////

  for (genvar b = 0; b < vrf_pkg::NrBanks; b++) begin : g_bank
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        hp_ptr_q[b] <= '0;
        lp_ptr_q[b] <= '0;
      end else begin
        // Only the level that won moves on
        if (hp_valid[b]) begin
          hp_ptr_q[b] <= (hp_win[b] == midx_t'(opreq_pkg::NrMasters - 1)) ?
                         '0 : hp_win[b] + 1'b1;
        end else if (lp_valid[b]) begin
          lp_ptr_q[b] <= (lp_win[b] == midx_t'(opreq_pkg::NrMasters - 1)) ?
                         '0 : lp_win[b] + 1'b1;
        end
      end
    end

    // At most one of the masters addressing this bank is granted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(mst_gnt & bank_req[b]));
  end

endmodule

// ==== verilog/operand_requester_top.sv ====
// Lane operand requester

`timescale 1ns/100ps

module operand_requester_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // Global hazard table, one row per instruction ID
  input  vrf_pkg::hazard_vec_t [vrf_pkg::NrVInsn-1:0]          global_hazard_table_i,
  // Operand requests and operand queues
  input  opreq_pkg::operand_request_t   [opreq_pkg::NrOperandQueues-1:0] operand_request_i,
  input  logic                          [opreq_pkg::NrOperandQueues-1:0] operand_request_valid_i,
  output logic                          [opreq_pkg::NrOperandQueues-1:0] operand_request_ready_o,
  output opreq_pkg::operand_queue_cmd_t [opreq_pkg::NrOperandQueues-1:0] operand_queue_cmd_o,
  output logic                          [opreq_pkg::NrOperandQueues-1:0] operand_queue_cmd_valid_o,
  input  logic                          [opreq_pkg::NrOperandQueues-1:0] operand_queue_ready_i,
  output logic                          [opreq_pkg::NrOperandQueues-1:0] operand_issued_o,
  // ALU result write
  input  logic                                                  alu_req_i,
  input  vrf_pkg::vid_t                                         alu_id_i,
  input  vrf_pkg::vaddr_t                                       alu_addr_i,
  input  vrf_pkg::elen_t                                        alu_wdata_i,
  input  vrf_pkg::strb_t                                        alu_be_i,
  output logic                                                  alu_gnt_o,
  // Load result write
  input  logic                                                  ldu_req_i,
  input  vrf_pkg::vid_t                                         ldu_id_i,
  input  vrf_pkg::vaddr_t                                       ldu_addr_i,
  input  vrf_pkg::elen_t                                        ldu_wdata_i,
  input  vrf_pkg::strb_t                                        ldu_be_i,
  output logic                                                  ldu_gnt_o,
  // VRF banks
  output logic                [vrf_pkg::NrBanks-1:0]           vrf_req_o,
  output vrf_pkg::vaddr_t     [vrf_pkg::NrBanks-1:0]           vrf_addr_o,
  output logic                [vrf_pkg::NrBanks-1:0]           vrf_wen_o,
  output vrf_pkg::elen_t      [vrf_pkg::NrBanks-1:0]           vrf_wdata_o,
  output vrf_pkg::strb_t      [vrf_pkg::NrBanks-1:0]           vrf_be_o,
  output opreq_pkg::opqueue_e [vrf_pkg::NrBanks-1:0]           vrf_tgt_o
);

  vrf_master_if mst_if [opreq_pkg::NrMasters] ();

  //////////////////////////////////////////////////
  // Load stream register
  //////////////////////////////////////////////////

  logic            ldu_valid_q;
  logic            ldu_drain;
  vrf_pkg::vid_t   ldu_id_q;
  vrf_pkg::vaddr_t ldu_addr_q;
  vrf_pkg::elen_t  ldu_wdata_q;
  vrf_pkg::strb_t  ldu_be_q;

  assign ldu_drain = mst_if[opreq_pkg::LoadWriteMaster].gnt;

  // Accept while empty or while the held entry leaves
  assign ldu_gnt_o = ldu_req_i && (!ldu_valid_q || ldu_drain);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_gnt_o) begin
      ldu_valid_q <= 1'b1;
    end else if (ldu_drain) begin
      ldu_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_gnt_o) begin
      ldu_id_q    <= ldu_id_i;
      ldu_addr_q  <= ldu_addr_i;
      ldu_wdata_q <= ldu_wdata_i;
      ldu_be_q    <= ldu_be_i;
    end
  end

  assign mst_if[opreq_pkg::LoadWriteMaster].req   = ldu_valid_q;
  assign mst_if[opreq_pkg::LoadWriteMaster].addr  = ldu_addr_q;
  assign mst_if[opreq_pkg::LoadWriteMaster].wen   = 1'b1;
  assign mst_if[opreq_pkg::LoadWriteMaster].wdata = ldu_wdata_q;
  assign mst_if[opreq_pkg::LoadWriteMaster].be    = ldu_be_q;
  assign mst_if[opreq_pkg::LoadWriteMaster].tgt   = opreq_pkg::ALU_A;

  // Held entry must not change until the bank takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_valid_q && !ldu_drain |=>
      $stable({ldu_valid_q, ldu_id_q, ldu_addr_q, ldu_wdata_q, ldu_be_q}));

  //////////////////////////////////////////////////
  // ALU write
  //////////////////////////////////////////////////

  assign mst_if[opreq_pkg::AluWriteMaster].req   = alu_req_i;
  assign mst_if[opreq_pkg::AluWriteMaster].addr  = alu_addr_i;
  assign mst_if[opreq_pkg::AluWriteMaster].wen   = 1'b1;
  assign mst_if[opreq_pkg::AluWriteMaster].wdata = alu_wdata_i;
  assign mst_if[opreq_pkg::AluWriteMaster].be    = alu_be_i;
  assign mst_if[opreq_pkg::AluWriteMaster].tgt   = opreq_pkg::ALU_A;

  assign alu_gnt_o = mst_if[opreq_pkg::AluWriteMaster].gnt;

  //////////////////////////////////////////////////
  // Write tracking
  //////////////////////////////////////////////////

  vrf_pkg::hazard_vec_t written_d, written_q;

  // Which instructions write a result this cycle
  always_comb begin
    written_d = '0;
    if (alu_gnt_o) begin
      written_d[alu_id_i] = 1'b1;
    end
    if (ldu_drain) begin
      written_d[ldu_id_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else begin
      written_q <= written_d;
    end
  end

  //////////////////////////////////////////////////
  // Fetch units and arbiter
  //////////////////////////////////////////////////

  for (genvar q = 0; q < opreq_pkg::NrOperandQueues; q++) begin : g_fetch
    operand_fetch_unit #(
      .Queue(opreq_pkg::opqueue_e'(q))
    ) u_fetch (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .request_i        (operand_request_i[q]),
      .request_valid_i  (operand_request_valid_i[q]),
      .request_ready_o  (operand_request_ready_o[q]),
      .queue_cmd_o      (operand_queue_cmd_o[q]),
      .queue_cmd_valid_o(operand_queue_cmd_valid_o[q]),
      .queue_ready_i    (operand_queue_ready_i[q]),
      .issued_o         (operand_issued_o[q]),
      .hazard_table_i   (global_hazard_table_i),
      .written_i        (written_q),
      .vrf_o            (mst_if[q])
    );
  end

  vrf_bank_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .masters    (mst_if),
    .vrf_req_o  (vrf_req_o),
    .vrf_addr_o (vrf_addr_o),
    .vrf_wen_o  (vrf_wen_o),
    .vrf_wdata_o(vrf_wdata_o),
    .vrf_be_o   (vrf_be_o),
    .vrf_tgt_o  (vrf_tgt_o)
  );

endmodule

// ==== bench/tb_operand_requester.sv ====
// Operand requester testbench

`timescale 1ns/100ps

module tb_operand_requester;

  localparam int Timeout = 2000;

  logic clk_i;
  logic rst_ni;

  vrf_pkg::hazard_vec_t [vrf_pkg::NrVInsn-1:0] hazard_table;
  opreq_pkg::operand_request_t   [3:0] op_req;
  opreq_pkg::operand_queue_cmd_t [3:0] op_cmd;
  logic [3:0] op_req_valid;
  logic [3:0] op_req_ready;
  logic [3:0] op_cmd_valid;
  logic [3:0] op_queue_ready;
  logic [3:0] op_issued;

  logic            alu_req;
  vrf_pkg::vid_t   alu_id;
  vrf_pkg::vaddr_t alu_addr;
  vrf_pkg::elen_t  alu_wdata;
  vrf_pkg::strb_t  alu_be;
  logic            alu_gnt;
  logic            ldu_req;
  vrf_pkg::vid_t   ldu_id;
  vrf_pkg::vaddr_t ldu_addr;
  vrf_pkg::elen_t  ldu_wdata;
  vrf_pkg::strb_t  ldu_be;
  logic            ldu_gnt;

  logic                [3:0] vrf_req;
  vrf_pkg::vaddr_t     [3:0] vrf_addr;
  logic                [3:0] vrf_wen;
  vrf_pkg::elen_t      [3:0] vrf_wdata;
  vrf_pkg::strb_t      [3:0] vrf_be;
  opreq_pkg::opqueue_e [3:0] vrf_tgt;

  // Expected traffic
  int          exp_addr [4][$];
  int          exp_words [4];
  int          issued_cnt [4];
  int          ld_addr_q [$];
  logic [63:0] ld_data_q [$];
  int          ld_be_q [$];
  int          alu_sent, alu_seen, ld_sent, ld_seen;
  int          mismatches, failures;
  logic [15:0] lfsr;

  // Hazard stall tracking
  bit hz_en;
  int hz_q, hz_k, hz_reads, hz_writes;

  operand_requester_top dut0 (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .global_hazard_table_i    (hazard_table),
    .operand_request_i        (op_req),
    .operand_request_valid_i  (op_req_valid),
    .operand_request_ready_o  (op_req_ready),
    .operand_queue_cmd_o      (op_cmd),
    .operand_queue_cmd_valid_o(op_cmd_valid),
    .operand_queue_ready_i    (op_queue_ready),
    .operand_issued_o         (op_issued),
    .alu_req_i                (alu_req),
    .alu_id_i                 (alu_id),
    .alu_addr_i               (alu_addr),
    .alu_wdata_i              (alu_wdata),
    .alu_be_i                 (alu_be),
    .alu_gnt_o                (alu_gnt),
    .ldu_req_i                (ldu_req),
    .ldu_id_i                 (ldu_id),
    .ldu_addr_i               (ldu_addr),
    .ldu_wdata_i              (ldu_wdata),
    .ldu_be_i                 (ldu_be),
    .ldu_gnt_o                (ldu_gnt),
    .vrf_req_o                (vrf_req),
    .vrf_addr_o               (vrf_addr),
    .vrf_wen_o                (vrf_wen),
    .vrf_wdata_o              (vrf_wdata),
    .vrf_be_o                 (vrf_be),
    .vrf_tgt_o                (vrf_tgt)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};
    end
  endtask

  // One 64-bit word holds 2^(3-eew) elements
  function automatic int word_count(input int eew, input int vl);
    int per_word;
    per_word = 1 << (3 - eew);
    return (vl + per_word - 1) / per_word;
  endfunction

  // Word k of register vs, wrapping in the 8-bit address space
  function automatic int expected_addr(input int vs, input int k);
    return (vs * 8 + k) % 256;
  endfunction

  function automatic bit reads_pending();
    for (int q = 0; q < 4; q++) begin
      if (exp_addr[q].size() != 0) return 1'b1;
    end
    return 1'b0;
  endfunction

  //////////////////////////////////////////////////
  // Checks and end of run
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    report_failure({"timeout, ", what});
    finish_run();
  endtask

  //////////////////////////////////////////////////
  // VRF monitor and comparison
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    int ab;
    int q;
    int full;
    if (rst_ni) begin
      ab = int'(alu_addr[1:0]);
      for (int i = 0; i < 4; i++) begin
        if (op_issued[i]) issued_cnt[i]++;
      end
      // ALU write lands on its bank in the grant cycle
      if (alu_gnt) begin
        alu_seen++;
        check_value("vrf_req_o of ALU bank", vrf_req[ab], 1);
        check_value("vrf_wen_o of ALU bank", vrf_wen[ab], 1);
        check_value("vrf_addr_o of ALU bank", vrf_addr[ab], alu_addr >> 2);
        check_value("vrf_wdata_o of ALU bank", vrf_wdata[ab], alu_wdata);
        check_value("vrf_be_o of ALU bank", vrf_be[ab], alu_be);
        if (hz_en && int'(alu_id) == hz_k) hz_writes++;
      end
      for (int b = 0; b < 4; b++) begin
        full = int'(vrf_addr[b]) * 4 + b;
        if (vrf_req[b] && !(alu_gnt && b == ab)) begin
          if (!vrf_wen[b]) begin
            q = int'(vrf_tgt[b]);
            if (!op_queue_ready[q]) begin
              report_failure($sformatf("read of queue %0d while its ready is low", q));
            end
            if (exp_addr[q].size() == 0) begin
              report_failure($sformatf("unexpected read of queue %0d on bank %0d", q, b));
            end else begin
              check_value($sformatf("read word address of queue %0d", q), full,
                          exp_addr[q].pop_front());
            end
            if (hz_en && q == hz_q) begin
              hz_reads++;
              if (hz_reads > hz_writes) begin
                report_failure("read issued while stalled on a hazard");
              end
            end
          end else if (ld_addr_q.size() == 0) begin
            report_failure($sformatf("unexpected write on bank %0d", b));
          end else begin
            ld_seen++;
            check_value("load write word address", full, ld_addr_q.pop_front());
            check_value("vrf_wdata_o of load write", vrf_wdata[b], ld_data_q.pop_front());
            check_value("vrf_be_o of load write", vrf_be[b], ld_be_q.pop_front());
          end
        end
      end
      if (ldu_gnt) begin
        ld_addr_q.push_back(int'(ldu_addr));
        ld_data_q.push_back(ldu_wdata);
        ld_be_q.push_back(int'(ldu_be));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic send_command(input int q, input int id, input int vs, input int eew,
                              input int vl, input vrf_pkg::hazard_vec_t hazard);
    opreq_pkg::operand_request_t cmd;
    int n;
    int waited;
    cmd.id     = vrf_pkg::vid_t'(id);
    cmd.vs     = 5'(vs);
    cmd.eew    = opreq_pkg::eew_e'(eew);
    cmd.vl     = opreq_pkg::vlen_t'(vl);
    cmd.hazard = hazard;
    @(posedge clk_i);
    op_req[q]       <= cmd;
    op_req_valid[q] <= 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (!op_req_ready[q] && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!op_req_ready[q]) begin
      timeout_abort($sformatf("command on queue %0d was not accepted", q));
    end else begin
      check_value("operand_queue_cmd_valid_o", op_cmd_valid[q], vl != 0);
      if (vl != 0) begin
        check_value("operand_queue_cmd_o eew", op_cmd[q].eew, eew);
        check_value("operand_queue_cmd_o vl", op_cmd[q].vl, vl);
      end
      n = word_count(eew, vl);
      for (int k = 0; k < n; k++) begin
        exp_addr[q].push_back(expected_addr(vs, k));
      end
      exp_words[q] += n;
      @(posedge clk_i);
      op_req_valid[q] <= 1'b0;
    end
  endtask

  task automatic random_commands(input vrf_pkg::hazard_vec_t hazard);
    logic [63:0] r;
    int vs;
    int eew;
    int vl;
    for (int q = 0; q < 4; q++) begin
      rand_bits(5, r);
      vs = int'(r[4:0]);
      rand_bits(2, r);
      eew = int'(r[1:0]);
      rand_bits(6, r);
      vl = int'(r[5:0]) + 1;
      rand_bits(3, r);
      send_command(q, int'(r[2:0]), vs, eew, vl, hazard);
    end
  endtask

  task automatic wait_reads_done(input bit toggle_ready);
    logic [63:0] r;
    int waited;
    waited = 0;
    while (reads_pending() && waited < Timeout) begin
      @(posedge clk_i);
      if (toggle_ready) begin
        rand_bits(4, r);
        op_queue_ready <= r[3:0];
      end
      waited++;
    end
    if (reads_pending()) begin
      timeout_abort("operand reads did not complete");
    end else begin
      @(posedge clk_i);
      op_queue_ready <= 4'hf;
    end
  endtask

  task automatic alu_write(input int id, input int addr);
    logic [63:0] data;
    logic [63:0] be;
    int waited;
    rand_bits(64, data);
    rand_bits(8, be);
    @(posedge clk_i);
    alu_req   <= 1'b1;
    alu_id    <= vrf_pkg::vid_t'(id);
    alu_addr  <= vrf_pkg::vaddr_t'(addr);
    alu_wdata <= data;
    alu_be    <= be[7:0];
    waited = 0;
    @(negedge clk_i);
    while (!alu_gnt && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!alu_gnt) begin
      timeout_abort("ALU write was never granted");
    end else begin
      alu_sent++;
      @(posedge clk_i);
      alu_req <= 1'b0;
    end
  endtask

  task automatic ldu_write(input int id, input int addr);
    logic [63:0] data;
    logic [63:0] be;
    int waited;
    rand_bits(64, data);
    rand_bits(8, be);
    @(posedge clk_i);
    ldu_req   <= 1'b1;
    ldu_id    <= vrf_pkg::vid_t'(id);
    ldu_addr  <= vrf_pkg::vaddr_t'(addr);
    ldu_wdata <= data;
    ldu_be    <= be[7:0];
    waited = 0;
    @(negedge clk_i);
    while (!ldu_gnt && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ldu_gnt) begin
      timeout_abort("load write was never accepted");
    end else begin
      ld_sent++;
      @(posedge clk_i);
      ldu_req <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [63:0] r;
    int waited;
    lfsr           = 16'd70;
    rst_ni         = 1'b0;
    hazard_table   = '1;
    op_req         = '0;
    op_req_valid   = '0;
    op_queue_ready = 4'hf;
    alu_req        = 1'b0;
    alu_id         = '0;
    alu_addr       = '0;
    alu_wdata      = '0;
    alu_be         = '0;
    ldu_req        = 1'b0;
    ldu_id         = '0;
    ldu_addr       = '0;
    ldu_wdata      = '0;
    ldu_be         = '0;
    hz_en          = 1'b0;

    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_value("operand_request_ready_o in reset", op_req_ready, 0);
    check_value("operand_queue_cmd_valid_o in reset", op_cmd_valid, 0);
    check_value("vrf_req_o in reset", vrf_req, 0);
    check_value("alu_gnt_o in reset", alu_gnt, 0);
    check_value("ldu_gnt_o in reset", ldu_gnt, 0);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // Plain read streams on all queues
    for (int round = 0; round < 3; round++) begin
      random_commands('0);
      wait_reads_done(1'b0);
    end

    // Zero-length commands
    for (int q = 0; q < 4; q++) begin
      send_command(q, q, 3, 1, 0, '0);
    end
    repeat (5) @(posedge clk_i);

    // Random back-pressure from the operand queues
    for (int round = 0; round < 2; round++) begin
      @(posedge clk_i);
      op_queue_ready <= 4'h0;
      random_commands('0);
      wait_reads_done(1'b1);
    end

    // ALU and load writes side by side
    fork
      for (int i = 0; i < 6; i++) begin
        rand_bits(11, r);
        alu_write(int'(r[10:8]), int'(r[7:0]));
      end
      for (int i = 0; i < 6; i++) begin
        rand_bits(11, r);
        ldu_write(int'(r[10:8]), int'(r[7:0]));
      end
    join
    waited = 0;
    while (ld_addr_q.size() != 0 && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (ld_addr_q.size() != 0) timeout_abort("load writes never reached the VRF");

    // ALU write and STORE_A read collide on bank 0
    @(posedge clk_i);
    op_queue_ready[opreq_pkg::STORE_A] <= 1'b0;
    send_command(int'(opreq_pkg::STORE_A), 1, 4, 3, 2, '0);
    @(posedge clk_i);
    alu_req   <= 1'b1;
    alu_id    <= 3'd3;
    alu_addr  <= 8'd100;
    alu_wdata <= 64'h0123_4567_89ab_cdef;
    alu_be    <= 8'hff;
    op_queue_ready[opreq_pkg::STORE_A] <= 1'b1;
    @(negedge clk_i);
    check_value("alu_gnt_o on bank conflict", alu_gnt, 1);
    check_value("vrf_wen_o of bank 0 on conflict", vrf_wen[0], 1);
    check_value("operand_issued_o of STORE_A on conflict", op_issued[2], 0);
    if (alu_gnt) alu_sent++;
    @(posedge clk_i);
    alu_req <= 1'b0;
    wait_reads_done(1'b0);

    // ALU_B command stalled on instruction 5
    hz_q      = int'(opreq_pkg::ALU_B);
    hz_k      = 5;
    hz_reads  = 0;
    hz_writes = 0;
    hz_en     = 1'b1;
    rand_bits(5, r);
    send_command(hz_q, 2, int'(r[4:0]), 3, 6, vrf_pkg::hazard_vec_t'(1 << hz_k));
    repeat (5) @(posedge clk_i);
    check_value("reads before any hazard write", hz_reads, 0);
    for (int i = 0; i < 3; i++) begin
      rand_bits(8, r);
      alu_write(hz_k, int'(r[7:0]));
      repeat (3) @(posedge clk_i);
    end
    @(posedge clk_i);
    hazard_table[2][hz_k] <= 1'b0;
    hz_en = 1'b0;
    wait_reads_done(1'b0);
    hazard_table[2] <= '1;

    repeat (10) @(posedge clk_i);
    for (int q = 0; q < 4; q++) begin
      check_value($sformatf("operand_issued_o pulses of queue %0d", q), issued_cnt[q],
                  exp_words[q]);
    end
    check_value("ALU writes seen on the VRF", alu_seen, alu_sent);
    check_value("load writes seen on the VRF", ld_seen, ld_sent);
    finish_run();
  end

endmodule

// ==== project.f ====
verilog/vrf_pkg.sv
verilog/opreq_pkg.sv
verilog/vrf_master_if.sv
verilog/operand_fetch_unit.sv
verilog/vrf_bank_arbiter.sv
verilog/operand_requester_top.sv
bench/tb_operand_requester.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the operand requester testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_operand_requester -f project.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
